// File: common/video_pkg.sv
package video_pkg;

	// ==============================
	// Pixel and coordinate types
	// ==============================

	// One colour channel
	typedef logic [7:0] color_t;

	// Packed colour, red low byte, green middle, blue high
	typedef logic [23:0] pixel_t;

	// Chunky 8-bit palette index
	typedef logic [7:0] pal_index_t;

	// Horizontal or vertical counter value
	typedef logic [10:0] coord_t;

	// ==============================
	// Default display timing
	// ==============================

	// 640 x 400 at 70 Hz, hsync negative, vsync positive
	localparam int DEF_H_LINE  = 800;
	localparam int DEF_H_BACK  = 48;
	localparam int DEF_H_FRONT = 16;
	localparam int DEF_H_PULSE = 96;
	localparam int DEF_V_LINE  = 449;
	localparam int DEF_V_BACK  = 35;
	localparam int DEF_V_FRONT = 12;
	localparam int DEF_V_PULSE = 2;
	localparam int DEF_HS_POL  = 0;
	localparam int DEF_VS_POL  = 1;

	localparam int DEF_FIFO_DEPTH = 16;

endpackage

// File: video_out/pixel_fetch.sv
`timescale 1ns/1ps

module pixel_fetch #(
	parameter int FIFO_DEPTH = video_pkg::DEF_FIFO_DEPTH
) (
	input  logic                 clock,
	input  logic                 i_rst_n,

	// Index stream
	input  logic                 i_pix_valid,
	input  video_pkg::pal_index_t i_pix_index,
	output logic                 o_pix_ready,

	// Palette write port
	input  logic                 i_pal_we,
	input  video_pkg::pal_index_t i_pal_addr,
	input  video_pkg::pixel_t     i_pal_color,

	// Credit link to the FIFO
	input  logic                 i_credit,
	output logic                 o_push,
	output video_pkg::pixel_t     o_push_pixel
);

	localparam int CW = $clog2(FIFO_DEPTH + 1);

	// Free slots downstream
	logic [CW-1:0] credits;
	logic          accept;

	video_pkg::pixel_t pal_mem [256];

	assign o_pix_ready = (credits != '0);
	assign accept = i_pix_valid && o_pix_ready;

	// ==============================
	// Credit counter
	// ==============================

	always_ff @(posedge clock) begin
		if (!i_rst_n) begin
			credits <= CW'(FIFO_DEPTH);
		end else begin
			case ({accept, i_credit})
				2'b10: credits <= credits - 1'b1;
				2'b01: credits <= credits + 1'b1;
				// Spend and return cancel
				default: credits <= credits;
			endcase
		end
	end

	// ==============================
	// Palette RAM and lookup
	// ==============================

	always_ff @(posedge clock) begin
		if (i_pal_we) begin
			pal_mem[i_pal_addr] <= i_pal_color;
		end
	end

	// Lookup sees the old entry on a same-cycle write
	always_ff @(posedge clock) begin
		if (accept) begin
			o_push_pixel <= pal_mem[i_pix_index];
		end
	end

	always_ff @(posedge clock) begin
		if (!i_rst_n) begin
			o_push <= 1'b0;
		end else begin
			o_push <= accept;
		end
	end

endmodule

// File: video_out/pixel_fifo.sv
`timescale 1ns/1ps

module pixel_fifo #(
	parameter int FIFO_DEPTH = video_pkg::DEF_FIFO_DEPTH
) (
	input  logic             clock,
	input  logic             i_rst_n,

	input  logic             i_push,
	input  video_pkg::pixel_t i_push_pixel,

	input  logic             i_pop,
	output video_pkg::pixel_t o_head,
	output logic             o_empty,

	// One pulse per pop, back to the fetch stage
	output logic             o_credit
);

	localparam int AW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CW = $clog2(FIFO_DEPTH + 1);

	video_pkg::pixel_t mem [FIFO_DEPTH];

	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [CW-1:0] count;
	logic          full;
	logic          do_push;
	logic          do_pop;

	assign full    = (count == CW'(FIFO_DEPTH));
	assign o_empty = (count == '0);
	assign do_push = i_push && !full;
	assign do_pop  = i_pop && !o_empty;

	// Show-ahead head, credit on the pop edge
	assign o_head   = mem[rd_ptr];
	assign o_credit = do_pop;

	always_ff @(posedge clock) begin
		if (do_push) begin
			mem[wr_ptr] <= i_push_pixel;
		end
	end

	// ==============================
	// Pointers and occupancy
	// ==============================

	always_ff @(posedge clock) begin
		if (!i_rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= (wr_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			if (do_push && !do_pop) begin
				count <= count + 1'b1;
			end else if (do_pop && !do_push) begin
				count <= count - 1'b1;
			end
		end
	end

endmodule

// File: video_out/display_timing.sv
`timescale 1ns/1ps

module display_timing #(
	parameter int H_LINE  = video_pkg::DEF_H_LINE,
	parameter int H_BACK  = video_pkg::DEF_H_BACK,
	parameter int H_FRONT = video_pkg::DEF_H_FRONT,
	parameter int H_PULSE = video_pkg::DEF_H_PULSE,
	parameter int V_LINE  = video_pkg::DEF_V_LINE,
	parameter int V_BACK  = video_pkg::DEF_V_BACK,
	parameter int V_FRONT = video_pkg::DEF_V_FRONT,
	parameter int V_PULSE = video_pkg::DEF_V_PULSE,
	parameter int HS_POL  = video_pkg::DEF_HS_POL,
	parameter int VS_POL  = video_pkg::DEF_VS_POL
) (
	input  logic             clock,
	input  logic             i_rst_n,

	// FIFO head
	input  logic             i_empty,
	input  video_pkg::pixel_t i_head,
	output logic             o_pop,

	// Video out
	output logic             o_de,
	output logic             o_hsync,
	output logic             o_vsync,
	output video_pkg::color_t o_r,
	output video_pkg::color_t o_g,
	output video_pkg::color_t o_b,

	output logic             o_vblank_irq,
	output logic             o_underflow
);

	localparam int H_ACTIVE = H_LINE - H_BACK - H_FRONT - H_PULSE;
	localparam int V_ACTIVE = V_LINE - V_BACK - V_FRONT - V_PULSE;

	// Line order is sync, back porch, active, front porch
	localparam video_pkg::coord_t H_SYNC_END = video_pkg::coord_t'(H_PULSE);
	localparam video_pkg::coord_t H_START    = video_pkg::coord_t'(H_PULSE + H_BACK);
	localparam video_pkg::coord_t H_END      = video_pkg::coord_t'(H_PULSE + H_BACK + H_ACTIVE);
	localparam video_pkg::coord_t H_LAST     = video_pkg::coord_t'(H_LINE - 1);
	localparam video_pkg::coord_t V_SYNC_END = video_pkg::coord_t'(V_PULSE);
	localparam video_pkg::coord_t V_START    = video_pkg::coord_t'(V_PULSE + V_BACK);
	localparam video_pkg::coord_t V_END      = video_pkg::coord_t'(V_PULSE + V_BACK + V_ACTIVE);
	localparam video_pkg::coord_t V_LAST     = video_pkg::coord_t'(V_LINE - 1);

	// Active levels of the sync pulses
	localparam logic HS_ACT = (HS_POL != 0);
	localparam logic VS_ACT = (VS_POL != 0);

	video_pkg::coord_t h_cnt;
	video_pkg::coord_t v_cnt;

	logic h_act;
	logic v_act;
	logic de0;
	logic hs0;
	logic vs0;
	logic vblank0;
	logic vblank_q;
	logic irq0;
	video_pkg::pixel_t pix0;

	// First delay stage
	logic de1;
	logic hs1;
	logic vs1;
	logic irq1;
	logic uf1;
	video_pkg::pixel_t pix1;

	// ==============================
	// Position counters
	// ==============================

	always_ff @(posedge clock) begin
		if (!i_rst_n) begin
			h_cnt <= '0;
			v_cnt <= '0;
		end else if (h_cnt == H_LAST) begin
			h_cnt <= '0;
			v_cnt <= (v_cnt == V_LAST) ? '0 : v_cnt + 1'b1;
		end else begin
			h_cnt <= h_cnt + 1'b1;
		end
	end

	assign h_act   = (h_cnt >= H_START) && (h_cnt < H_END);
	assign v_act   = (v_cnt >= V_START) && (v_cnt < V_END);
	assign de0     = h_act && v_act;
	assign hs0     = (h_cnt < H_SYNC_END) ? HS_ACT : !HS_ACT;
	assign vs0     = (v_cnt < V_SYNC_END) ? VS_ACT : !VS_ACT;
	assign vblank0 = !v_act;

	// Rise of vertical blank
	assign irq0 = vblank0 && !vblank_q;

	// Never stall, show black when starved
	assign o_pop = de0 && !i_empty;
	assign pix0  = o_pop ? i_head : '0;

	// ==============================
	// Two-stage output delay
	// ==============================

	always_ff @(posedge clock) begin
		if (!i_rst_n) begin
			// Counters start in vblank, so no pulse right after reset
			vblank_q     <= 1'b1;
			de1          <= 1'b0;
			hs1          <= !HS_ACT;
			vs1          <= !VS_ACT;
			irq1         <= 1'b0;
			uf1          <= 1'b0;
			o_de         <= 1'b0;
			o_hsync      <= !HS_ACT;
			o_vsync      <= !VS_ACT;
			o_vblank_irq <= 1'b0;
			o_underflow  <= 1'b0;
		end else begin
			vblank_q     <= vblank0;
			de1          <= de0;
			hs1          <= hs0;
			vs1          <= vs0;
			irq1         <= irq0;
			uf1          <= de0 && i_empty;
			o_de         <= de1;
			o_hsync      <= hs1;
			o_vsync      <= vs1;
			o_vblank_irq <= irq1;
			// Sticky until reset
			o_underflow  <= o_underflow || uf1;
		end
	end

	always_ff @(posedge clock) begin
		pix1 <= pix0;
		o_r  <= pix1[7:0];
		o_g  <= pix1[15:8];
		o_b  <= pix1[23:16];
	end

endmodule

// File: source/video_top.sv
`timescale 1ns/1ps

module video_top #(
	parameter int H_LINE     = video_pkg::DEF_H_LINE,
	parameter int H_BACK     = video_pkg::DEF_H_BACK,
	parameter int H_FRONT    = video_pkg::DEF_H_FRONT,
	parameter int H_PULSE    = video_pkg::DEF_H_PULSE,
	parameter int V_LINE     = video_pkg::DEF_V_LINE,
	parameter int V_BACK     = video_pkg::DEF_V_BACK,
	parameter int V_FRONT    = video_pkg::DEF_V_FRONT,
	parameter int V_PULSE    = video_pkg::DEF_V_PULSE,
	parameter int HS_POL     = video_pkg::DEF_HS_POL,
	parameter int VS_POL     = video_pkg::DEF_VS_POL,
	parameter int FIFO_DEPTH = video_pkg::DEF_FIFO_DEPTH
) (
	input  logic                 clock,
	input  logic                 i_rst_n,

	input  logic                 i_pix_valid,
	input  video_pkg::pal_index_t i_pix_index,
	output logic                 o_pix_ready,

	input  logic                 i_pal_we,
	input  video_pkg::pal_index_t i_pal_addr,
	input  video_pkg::pixel_t     i_pal_color,

	output logic                 o_de,
	output logic                 o_hsync,
	output logic                 o_vsync,
	output video_pkg::color_t     o_r,
	output video_pkg::color_t     o_g,
	output video_pkg::color_t     o_b,

	output logic                 o_vblank_irq,
	output logic                 o_underflow
);

	// ==============================
	// Fetch to FIFO
	// ==============================

	logic              push;
	video_pkg::pixel_t push_pixel;
	logic              credit;

	pixel_fetch #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) fetch0 (
		.clock       (clock),
		.i_rst_n     (i_rst_n),
		.i_pix_valid (i_pix_valid),
		.i_pix_index (i_pix_index),
		.o_pix_ready (o_pix_ready),
		.i_pal_we    (i_pal_we),
		.i_pal_addr  (i_pal_addr),
		.i_pal_color (i_pal_color),
		.i_credit    (credit),
		.o_push      (push),
		.o_push_pixel(push_pixel)
	);

	// FIFO to display
	logic              pop;
	logic              empty;
	video_pkg::pixel_t head;

	pixel_fifo #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) fifo0 (
		.clock       (clock),
		.i_rst_n     (i_rst_n),
		.i_push      (push),
		.i_push_pixel(push_pixel),
		.i_pop       (pop),
		.o_head      (head),
		.o_empty     (empty),
		.o_credit    (credit)
	);

	display_timing #(
		.H_LINE (H_LINE),
		.H_BACK (H_BACK),
		.H_FRONT(H_FRONT),
		.H_PULSE(H_PULSE),
		.V_LINE (V_LINE),
		.V_BACK (V_BACK),
		.V_FRONT(V_FRONT),
		.V_PULSE(V_PULSE),
		.HS_POL (HS_POL),
		.VS_POL (VS_POL)
	) timing0 (
		.clock       (clock),
		.i_rst_n     (i_rst_n),
		.i_empty     (empty),
		.i_head      (head),
		.o_pop       (pop),
		.o_de        (o_de),
		.o_hsync     (o_hsync),
		.o_vsync     (o_vsync),
		.o_r         (o_r),
		.o_g         (o_g),
		.o_b         (o_b),
		.o_vblank_irq(o_vblank_irq),
		.o_underflow (o_underflow)
	);

endmodule

// File: tests/video_assertions.sv
`timescale 1ns/1ps

module video_assertions #(
	parameter int FIFO_DEPTH = 4
) (
	input logic                               clock,
	input logic                               i_rst_n,
	input logic                               i_push,
	input logic                               i_pop,
	input logic                               i_empty,
	input logic                               i_credit,
	input logic [$clog2(FIFO_DEPTH + 1)-1:0] i_count
);

	// Credits keep the fetch stage from overrunning
	push_not_full: assert property (@(posedge clock) disable iff (!i_rst_n)
		!(i_push && i_count == FIFO_DEPTH))
		else $error("push into a full pixel FIFO");

	pop_not_empty: assert property (@(posedge clock) disable iff (!i_rst_n)
		!(i_pop && i_empty))
		else $error("pop from an empty pixel FIFO");

	// Every pop hands back exactly one credit
	credit_with_pop: assert property (@(posedge clock) disable iff (!i_rst_n)
		i_credit == i_pop)
		else $error("credit pulse does not match a pop");

endmodule

bind pixel_fifo video_assertions #(.FIFO_DEPTH(FIFO_DEPTH)) checks0 (
	.clock(clock), .i_rst_n(i_rst_n), .i_push(i_push), .i_pop(i_pop),
	.i_empty(o_empty), .i_credit(o_credit), .i_count(count)
);

// File: tests/tb_video.sv
`timescale 1ns/1ps

module tb_video;

	localparam int DEPTH   = 4;
	localparam int H_ACT   = 16;
	localparam int V_ACT   = 9;
	localparam int HS_LEN  = 3;
	localparam int VS_LEN  = 2 * 24;
	localparam int TIMEOUT = 2000;
	localparam int PASSES  = 10;

	logic                  clock;
	logic                  i_rst_n;
	logic                  i_pix_valid;
	video_pkg::pal_index_t i_pix_index;
	logic                  o_pix_ready;
	logic                  i_pal_we;
	video_pkg::pal_index_t i_pal_addr;
	video_pkg::pixel_t     i_pal_color;
	logic                  o_de;
	logic                  o_hsync;
	logic                  o_vsync;
	video_pkg::color_t     o_r;
	video_pkg::color_t     o_g;
	video_pkg::color_t     o_b;
	logic                  o_vblank_irq;
	logic                  o_underflow;

	// Reference model and stimulus
	video_pkg::pixel_t     pal_model [256];
	video_pkg::pal_index_t pal_idx_q [$];
	video_pkg::pixel_t     pal_col_q [$];
	video_pkg::pal_index_t stream_q [$];
	video_pkg::pixel_t     exp_q [$];
	logic [31:0]           lcg_state = 32'h9b5f_6499;

	int    errs [7];
	string names [7] = '{"palette", "pixel stream", "line and frame", "sync",
		"vblank irq", "ready back-pressure", "underflow"};
	int    accepted;
	int    last_gap;
	int    de_run;
	int    hs_run;
	int    vs_run;
	int    lines;
	int    irqs;
	int    black_seen;
	logic  de_since_irq;
	logic  starving;
	logic  monitor_on;

	video_top #(
		.H_LINE(24), .H_BACK(3), .H_FRONT(2), .H_PULSE(3),
		.V_LINE(14), .V_BACK(2), .V_FRONT(1), .V_PULSE(2),
		.HS_POL(0), .VS_POL(1), .FIFO_DEPTH(DEPTH)
	) dut0 (
		.clock(clock), .i_rst_n(i_rst_n),
		.i_pix_valid(i_pix_valid), .i_pix_index(i_pix_index), .o_pix_ready(o_pix_ready),
		.i_pal_we(i_pal_we), .i_pal_addr(i_pal_addr), .i_pal_color(i_pal_color),
		.o_de(o_de), .o_hsync(o_hsync), .o_vsync(o_vsync),
		.o_r(o_r), .o_g(o_g), .o_b(o_b),
		.o_vblank_irq(o_vblank_irq), .o_underflow(o_underflow)
	);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic check(input int t, input logic ok, input string msg);
		assert (ok) else begin
			$display("Fail %0t: %s", $time, msg);
			errs[t]++;
		end
	endtask

	task automatic abort_on_timeout(input string what);
		$display("timed out waiting for %s", what);
		$display("tests failed");
		$finish;
	endtask

	task automatic report(input int t);
		if (errs[t] == 0) begin
			$display("%s: ok", names[t]);
		end else begin
			$display("%s: %0d errors", names[t], errs[t]);
		end
	endtask

	// ==============================
	// Stimulus file
	// ==============================

	task automatic load_stim();
		int                    fd;
		int                    n;
		string                 line;
		byte                   kind;
		video_pkg::pal_index_t a;
		video_pkg::pixel_t     b;
		logic                  done;
		done = 1'b0;
		fd = $fopen("tests/video_stim.txt", "r");
		if (fd == 0) begin
			$display("could not open the stimulus file tests/video_stim.txt");
			errs[0]++;
		end else begin
			while (!$feof(fd) && !done) begin
				n = $fgets(line, fd);
				if (n > 1 && line.getc(0) != "#") begin
					n = $sscanf(line, "%c %h %h", kind, a, b);
					if (kind == "P") begin
						pal_idx_q.push_back(a);
						pal_col_q.push_back(b);
						pal_model[a] = b;
					end else if (kind == "S") begin
						check(0, pal_model[a] == b,
							$sformatf("stim colour %06h for index %02h", b, a));
						stream_q.push_back(a);
					end else if (kind == "X") begin
						done = 1'b1;
					end
				end
			end
			$fclose(fd);
		end
	endtask

	// Caller sits on a rising edge
	task automatic send_pixel(input video_pkg::pal_index_t idx);
		int waited;
		waited = 0;
		i_pix_valid <= 1'b1;
		i_pix_index <= idx;
		@(negedge clock);
		while (!o_pix_ready && waited <= TIMEOUT) begin
			waited++;
			@(negedge clock);
		end
		if (waited > TIMEOUT) begin
			abort_on_timeout("o_pix_ready during the stream");
		end else begin
			@(posedge clock);
			exp_q.push_back(pal_model[idx]);
			accepted++;
			// Occasional idle cycle, at most one per line
			lcg_state = lcg_next(lcg_state);
			if (lcg_state[31:29] == 3'd0 && accepted - last_gap >= 24) begin
				last_gap = accepted;
				i_pix_valid <= 1'b0;
				@(posedge clock);
			end
		end
	endtask

	task automatic watch_ready();
		int waited;
		waited = 0;
		@(negedge clock);
		while (o_pix_ready && waited <= TIMEOUT) begin
			waited++;
			@(negedge clock);
		end
		if (waited > TIMEOUT) begin
			abort_on_timeout("o_pix_ready to fall");
		end else begin
			check(5, accepted <= DEPTH, $sformatf("ready fell after %0d indices", accepted));
			waited = 0;
			while (!o_pix_ready && waited <= TIMEOUT) begin
				waited++;
				@(negedge clock);
			end
			if (waited > TIMEOUT) begin
				abort_on_timeout("o_pix_ready to rise after display pops");
			end else begin
				report(5);
			end
		end
	endtask

	// ==============================
	// Output monitor
	// ==============================

	always @(negedge clock) begin
		if (i_rst_n && monitor_on) begin
			if (o_de) begin
				if (exp_q.size() > 0) begin
					check(1, {o_b, o_g, o_r} == exp_q[0] && !o_underflow,
						$sformatf("pixel %06h expected %06h", {o_b, o_g, o_r}, exp_q[0]));
					void'(exp_q.pop_front());
				end else begin
					check(1, starving, "display ran out of pixels during the stream");
					check(6, {o_b, o_g, o_r} == 24'h0,
						$sformatf("starved pixel %06h is not black", {o_b, o_g, o_r}));
					black_seen++;
				end
				check(3, o_hsync && !o_vsync, "data enable during a sync pulse");
				de_run++;
				de_since_irq = 1'b1;
			end else if (de_run != 0) begin
				check(2, de_run == H_ACT, $sformatf("line with %0d enabled cycles", de_run));
				de_run = 0;
				lines++;
			end
			if (!o_hsync) begin
				hs_run++;
			end else if (hs_run != 0) begin
				check(3, hs_run == HS_LEN, $sformatf("hsync low for %0d cycles", hs_run));
				hs_run = 0;
			end
			if (o_vsync) begin
				vs_run++;
			end else if (vs_run != 0) begin
				check(3, vs_run == VS_LEN, $sformatf("vsync high for %0d cycles", vs_run));
				vs_run = 0;
			end
			if (o_vblank_irq) begin
				check(4, de_since_irq && !o_de, "vblank pulse without a frame before it");
				check(2, lines == V_ACT, $sformatf("frame with %0d lines", lines));
				lines = 0;
				de_since_irq = 1'b0;
				irqs++;
			end
		end
	end

	// ==============================
	// Test sequence
	// ==============================

	initial begin
		int waited;
		int total;
		i_rst_n      = 1'b0;
		i_pix_valid  = 1'b0;
		i_pix_index  = '0;
		i_pal_we     = 1'b0;
		i_pal_addr   = '0;
		i_pal_color  = '0;
		starving     = 1'b0;
		monitor_on   = 1'b0;
		de_since_irq = 1'b0;
		load_stim();
		repeat (2) @(posedge clock);
		i_rst_n <= 1'b1;
		@(negedge clock);
		check(3, o_hsync && !o_vsync && !o_de, "outputs not idle after reset");
		check(5, o_pix_ready, "ready low after reset");
		check(6, !o_underflow && !o_vblank_irq, "flags set after reset");
		monitor_on = 1'b1;
		@(posedge clock);
		foreach (pal_idx_q[i]) begin
			i_pal_we    <= 1'b1;
			i_pal_addr  <= pal_idx_q[i];
			i_pal_color <= pal_col_q[i];
			@(posedge clock);
		end
		i_pal_we <= 1'b0;
		report(0);
		fork
			watch_ready();
			begin
				repeat (PASSES) begin
					foreach (stream_q[i]) begin
						send_pixel(stream_q[i]);
					end
				end
				i_pix_valid <= 1'b0;
				starving = 1'b1;
			end
		join
		waited = 0;
		while ((exp_q.size() > 0 || black_seen < 4) && waited <= TIMEOUT) begin
			waited++;
			@(negedge clock);
		end
		if (waited > TIMEOUT) begin
			abort_on_timeout("the stream to drain into black pixels");
		end else begin
			report(1);
			check(6, o_underflow, "underflow flag not set after starvation");
			repeat (30) @(negedge clock);
			check(6, o_underflow, "underflow flag dropped before reset");
			check(4, irqs >= 2, $sformatf("only %0d vblank pulses", irqs));
			report(2);
			report(3);
			report(4);
			monitor_on = 1'b0;
			@(posedge clock);
			i_rst_n <= 1'b0;
			repeat (2) @(posedge clock);
			i_rst_n <= 1'b1;
			@(negedge clock);
			check(6, !o_underflow, "underflow flag survived reset");
			report(6);
			total = 0;
			foreach (errs[t]) begin
				total += errs[t];
			end
			$display("tests: %0d errors over %0d tests", total, 7);
			if (total == 0) begin
				$display("all tests passed");
			end else begin
				$display("tests failed");
			end
			$finish;
		end
	end

endmodule

// File: tests/video_stim.txt
# P index colour : palette write, colour hex is blue green red
# S index colour : stream entry with its expected colour ; X : starvation marker
P 00 0000ff
P 01 00ff00
P 02 ff0000
P 07 123456
P 10 abcdef
P 3c 808080
P 80 0f1e2d
P ff ffffff
S 00 0000ff
S 01 00ff00
S 02 ff0000
S 07 123456
S 10 abcdef
S 3c 808080
S 80 0f1e2d
S ff ffffff
S ff ffffff
S 80 0f1e2d
S 3c 808080
S 10 abcdef
S 07 123456
S 02 ff0000
S 01 00ff00
S 00 0000ff
S 07 123456
S 07 123456
S 00 0000ff
S 10 abcdef
S 01 00ff00
S 3c 808080
S 02 ff0000
S 80 0f1e2d
S ff ffffff
S 00 0000ff
S 10 abcdef
S 80 0f1e2d
S 01 00ff00
S 3c 808080
S 02 ff0000
S 07 123456
X

// File: files.f
common/video_pkg.sv
video_out/pixel_fetch.sv
video_out/pixel_fifo.sv
video_out/display_timing.sv
source/video_top.sv
tests/video_assertions.sv
tests/tb_video.sv

// File: run.sh
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the log

verilator --binary --timing --assert --top-module tb_video -f files.f \
	--Mdir obj_dir -o sim_video > build.log 2>&1 \
	|| { echo "build failed, see build.log"; exit 1; }

./obj_dir/sim_video > sim.log 2>&1 ; true

grep -qx "all tests passed" sim.log \
	&& echo "PASS" \
	|| { echo "FAIL, see sim.log"; exit 1; }
